/* rtl/fetch_ctrl_pkg.sv */
////////////////////
// Fetch control definitions
////////////////////
`default_nettype none

package fetch_ctrl_pkg;

  // Fetch target selection, one code per redirect source
  typedef enum logic [3:0] {
    PC_BOOT     = 4'd0,
    PC_JUMP     = 4'd1,
    PC_BRANCH   = 4'd2,
    PC_MRET     = 4'd3,
    PC_DRET     = 4'd4,
    PC_TRAP_EXC = 4'd5,
    PC_TRAP_IRQ = 4'd6,
    PC_TRAP_DBD = 4'd7,
    PC_TRAP_DBE = 4'd8,
    PC_TRAP_NMI = 4'd9
  } pc_mux_e;

  ////////////////////
  // Prefetch buffer

  // Words held, words still in flight count too
  localparam int FETCH_DEPTH = 2;
  localparam int FETCH_PTR_W = $clog2(FETCH_DEPTH);
  localparam int FETCH_CNT_W = $clog2(FETCH_DEPTH + 1);
  // Stale plus live responses allowed across back-to-back redirects
  localparam int MAX_PENDING = 2 * FETCH_DEPTH;
  localparam int PEND_W      = $clog2(MAX_PENDING + 1);

  ////////////////////
  // Trap vectoring

  localparam int IRQ_ID_WIDTH     = 5;
  localparam int MTVEC_ADDR_WIDTH = 25;
  // Vector slot reserved for NMI
  localparam logic [IRQ_ID_WIDTH-1:0] NMI_MTVEC_INDEX = 5'd15;

endpackage

`default_nettype wire

/* rtl/rvc_pkg.sv */
////////////////////
// Compressed ISA encodings
////////////////////
`default_nettype none

package rvc_pkg;

  // Quadrant in bits [1:0]
  localparam logic [1:0] OPC_C0   = 2'b00;
  localparam logic [1:0] OPC_C1   = 2'b01;
  localparam logic [1:0] OPC_C2   = 2'b10;
  // Anything else is a compressed parcel
  localparam logic [1:0] OPC_RV32 = 2'b11;

  // funct3 in bits [15:13] of the kept forms
  localparam logic [2:0] F3_C_LW    = 3'b010;
  localparam logic [2:0] F3_C_SW    = 3'b110;
  localparam logic [2:0] F3_C_ADDI  = 3'b000;
  localparam logic [2:0] F3_C_LI    = 3'b010;
  localparam logic [2:0] F3_C_MVADD = 3'b100;

  // RV32I major opcodes produced by expansion
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_LD  = 7'b0000011;
  localparam logic [6:0] OP_ST  = 7'b0100011;
  localparam logic [6:0] OP_REG = 7'b0110011;

  // Fetched word, whole or as two halfword parcels
  typedef union packed {
    logic [31:0] word;
    struct packed {
      logic [15:0] hi;
      logic [15:0] lo;
    } parcel;
  } fetch_word_u;

endpackage

`default_nettype wire

/* rtl/pc_target_mux.sv */
////////////////////
// Fetch target select
////////////////////
`default_nettype none

module pc_target_mux (
  input  fetch_ctrl_pkg::pc_mux_e                      pc_mux_i,
  input  logic                                         pc_set_i,
  input  logic [31:0]                                  boot_addr_i,
  input  logic [31:0]                                  jump_target_i,
  input  logic [31:0]                                  branch_target_i,
  input  logic [31:0]                                  mepc_i,
  input  logic [31:0]                                  dpc_i,
  input  logic [31:0]                                  dm_halt_addr_i,
  input  logic [31:0]                                  dm_exception_addr_i,
  input  logic [fetch_ctrl_pkg::MTVEC_ADDR_WIDTH-1:0]  mtvec_addr_i,
  input  logic [fetch_ctrl_pkg::IRQ_ID_WIDTH-1:0]      irq_id_i,
  output logic [31:0]                                  branch_addr_o,
  output logic                                         csr_mtvec_init_o
);
  import fetch_ctrl_pkg::*;

  logic [31:0] target;

  always_comb begin
    target = {boot_addr_i[31:2], 2'b00};
    unique case (pc_mux_i)
      PC_BOOT:     target = {boot_addr_i[31:2], 2'b00};
      PC_JUMP:     target = jump_target_i;
      PC_BRANCH:   target = branch_target_i;
      // Return to the interrupted instruction
      PC_MRET:     target = mepc_i;
      PC_DRET:     target = dpc_i;
      // Exceptions share the vector base
      PC_TRAP_EXC: target = {mtvec_addr_i, 7'h00};
      // Interrupts are vectored, one word per slot
      PC_TRAP_IRQ: target = {mtvec_addr_i, irq_id_i, 2'b00};
      PC_TRAP_DBD: target = {dm_halt_addr_i[31:2], 2'b00};
      PC_TRAP_DBE: target = {dm_exception_addr_i[31:2], 2'b00};
      PC_TRAP_NMI: target = {mtvec_addr_i, NMI_MTVEC_INDEX, 2'b00};
      default: ;
    endcase
  end

  // Halfword alignment is all the fetch path ever needs
  assign branch_addr_o = {target[31:1], 1'b0};

  // CSR file loads its mtvec reset value on boot
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

endmodule

`default_nettype wire

/* rtl/prefetch_unit.sv */
////////////////////
// Word prefetcher
////////////////////
`default_nettype none

module prefetch_unit (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        pc_set_i,
  input  logic [31:0] branch_addr_i,
  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i,
  input  logic        instr_err_i,
  output logic        word_valid_o,
  input  logic        word_ready_i,
  output logic [31:0] word_o,
  output logic        word_err_o,
  output logic [31:0] word_addr_o,
  output logic        busy_o
);
  import fetch_ctrl_pkg::*;

  // Word buffer, one address and error flag per entry
  logic [31:0]            buf_data [FETCH_DEPTH];
  logic [31:0]            buf_addr [FETCH_DEPTH];
  logic                   buf_err  [FETCH_DEPTH];

  logic                   fetch_en_q;
  logic [31:0]            fetch_addr_q;
  logic [31:0]            resp_addr_q;
  logic [FETCH_PTR_W-1:0] rd_ptr_q;
  logic [FETCH_PTR_W-1:0] wr_ptr_q;
  logic [FETCH_CNT_W-1:0] count_q;
  logic [FETCH_CNT_W-1:0] out_cnt_q;
  logic [PEND_W-1:0]      discard_q;
  logic                   resp_keep;
  logic                   resp_drop;
  logic                   pop;
  logic [31:0]            target_word;

  assign target_word = {branch_addr_i[31:2], 2'b00};

  // Responses owed to a flushed stream are dropped first
  assign resp_drop = instr_rvalid_i && (discard_q != '0);
  assign resp_keep = instr_rvalid_i && (discard_q == '0);

  // Room for the word once it lands, and a bounded number in flight
  assign instr_req_o  = fetch_en_q && !pc_set_i &&
                        ((count_q + out_cnt_q) < FETCH_DEPTH) &&
                        ((out_cnt_q + discard_q) < MAX_PENDING);
  assign instr_addr_o = fetch_addr_q;

  assign word_valid_o = (count_q != '0);
  assign word_o       = buf_data[rd_ptr_q];
  assign word_err_o   = buf_err[rd_ptr_q];
  assign word_addr_o  = buf_addr[rd_ptr_q];
  assign pop          = word_valid_o && word_ready_i;

  assign busy_o = (out_cnt_q != '0) || (discard_q != '0);

  ////////////////////
  // Control state

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_en_q   <= 1'b0;
      fetch_addr_q <= '0;
      resp_addr_q  <= '0;
      rd_ptr_q     <= '0;
      wr_ptr_q     <= '0;
      count_q      <= '0;
      out_cnt_q    <= '0;
      discard_q    <= '0;
    end else if (pc_set_i) begin
      // Redirect empties the buffer and orphans every live request
      fetch_en_q   <= 1'b1;
      fetch_addr_q <= target_word;
      resp_addr_q  <= target_word;
      rd_ptr_q     <= '0;
      wr_ptr_q     <= '0;
      count_q      <= '0;
      out_cnt_q    <= '0;
      discard_q    <= discard_q + PEND_W'(out_cnt_q) - PEND_W'(instr_rvalid_i);
    end else begin
      out_cnt_q <= out_cnt_q + FETCH_CNT_W'(instr_req_o) - FETCH_CNT_W'(resp_keep);
      count_q   <= count_q + FETCH_CNT_W'(resp_keep) - FETCH_CNT_W'(pop);
      discard_q <= discard_q - PEND_W'(resp_drop);
      if (instr_req_o) begin
        fetch_addr_q <= fetch_addr_q + 32'd4;
      end
      if (resp_keep) begin
        wr_ptr_q    <= wr_ptr_q + 1'b1;
        resp_addr_q <= resp_addr_q + 32'd4;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Buffer storage
  always_ff @(posedge clk) begin
    if (resp_keep && !pc_set_i) begin
      buf_data[wr_ptr_q] <= instr_rdata_i;
      buf_addr[wr_ptr_q] <= resp_addr_q;
      buf_err[wr_ptr_q]  <= instr_err_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/instr_aligner.sv */
////////////////////
// Instruction aligner
////////////////////
`default_nettype none

module instr_aligner (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        pc_set_i,
  input  logic [31:0] branch_addr_i,
  input  logic        word_valid_i,
  input  logic [31:0] word_i,
  input  logic        word_err_i,
  input  logic [31:0] word_addr_i,
  output logic        word_ready_o,
  input  logic        halt_if_i,
  input  logic        kill_if_i,
  input  logic        id_ready_i,
  output logic [31:0] raw_instr_o,
  output logic        is_compressed_o,
  output logic        instr_err_o,
  output logic [31:0] pc_if_o,
  output logic        if_valid_o
);
  import rvc_pkg::*;

  fetch_word_u word;
  logic [31:0] pc_q;
  // Halfword at pc_q, left over from the previous word
  logic        resid_valid_q;
  logic [15:0] resid_q;
  logic        resid_err_q;
  logic        avail;
  logic        take_word;
  logic        save_hi;
  logic        fire;
  logic        park;
  logic        step;

  assign word = word_i;

  // Parcel selection
  always_comb begin
    avail           = 1'b0;
    take_word       = 1'b0;
    save_hi         = 1'b0;
    raw_instr_o     = '0;
    is_compressed_o = 1'b0;
    instr_err_o     = 1'b0;
    if (resid_valid_q) begin
      if (resid_q[1:0] != OPC_RV32) begin
        avail           = 1'b1;
        raw_instr_o     = {16'h0000, resid_q};
        is_compressed_o = 1'b1;
        instr_err_o     = resid_err_q;
      end else if (word_valid_i) begin
        // Straddling instruction, upper half comes from the new word
        avail       = 1'b1;
        take_word   = 1'b1;
        save_hi     = 1'b1;
        raw_instr_o = {word.parcel.lo, resid_q};
        instr_err_o = resid_err_q | word_err_i;
      end
    end else if (word_valid_i) begin
      if (!pc_q[1]) begin
        avail       = 1'b1;
        instr_err_o = word_err_i;
        if (word.parcel.lo[1:0] != OPC_RV32) begin
          // Word stays, its high parcel is next
          raw_instr_o     = {16'h0000, word.parcel.lo};
          is_compressed_o = 1'b1;
        end else begin
          raw_instr_o = word.word;
          take_word   = 1'b1;
        end
      end else if (word.parcel.hi[1:0] != OPC_RV32) begin
        avail           = 1'b1;
        take_word       = 1'b1;
        raw_instr_o     = {16'h0000, word.parcel.hi};
        is_compressed_o = 1'b1;
        instr_err_o     = word_err_i;
      end else begin
        // Start of a straddling instruction, park the high parcel
        take_word = 1'b1;
        save_hi   = 1'b1;
      end
    end
  end

  // Kill drops the instruction even when halted or stalled
  assign fire = avail && (kill_if_i || (!halt_if_i && id_ready_i));
  assign park = !avail && take_word && (kill_if_i || !halt_if_i);
  assign step = fire || park;

  assign word_ready_o = take_word && step;
  assign if_valid_o   = avail && !halt_if_i && !kill_if_i;
  assign pc_if_o      = (resid_valid_q || !word_valid_i) ? pc_q :
                        {word_addr_i[31:2], pc_q[1:0]};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q          <= '0;
      resid_valid_q <= 1'b0;
    end else if (pc_set_i) begin
      pc_q          <= branch_addr_i;
      resid_valid_q <= 1'b0;
    end else if (step) begin
      resid_valid_q <= save_hi;
      if (fire) begin
        pc_q <= pc_if_o + (is_compressed_o ? 32'd2 : 32'd4);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (step && save_hi) begin
      resid_q     <= word.parcel.hi;
      resid_err_q <= word_err_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/compressed_decoder.sv */
////////////////////
// RVC expander
////////////////////
`default_nettype none

module compressed_decoder (
  input  logic [31:0] raw_instr_i,
  input  logic        is_compressed_i,
  output logic [31:0] instr_o,
  output logic        illegal_o
);
  import rvc_pkg::*;

  fetch_word_u fw;
  logic [15:0] c;

  assign fw = raw_instr_i;
  assign c  = fw.parcel.lo;

  always_comb begin
    // Full-width instructions pass unchanged
    instr_o   = fw.word;
    illegal_o = 1'b0;
    if (is_compressed_i) begin
      // Unsupported forms leave the bare halfword
      instr_o   = {16'h0000, c};
      illegal_o = 1'b1;
      unique case (c[1:0])
        OPC_C0: begin
          // Registers x8..x15, word-scaled offsets
          if (c[15:13] == F3_C_LW) begin
            instr_o   = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7], 3'b010,
                         2'b01, c[4:2], OP_LD};
            illegal_o = 1'b0;
          end else if (c[15:13] == F3_C_SW) begin
            instr_o   = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7], 3'b010,
                         c[11:10], c[6], 2'b00, OP_ST};
            illegal_o = 1'b0;
          end
        end
        OPC_C1: begin
          // Sign-extended 6-bit immediate
          if (c[15:13] == F3_C_ADDI) begin
            instr_o   = {{6{c[12]}}, c[12], c[6:2], c[11:7], 3'b000, c[11:7], OP_IMM};
            illegal_o = 1'b0;
          end else if (c[15:13] == F3_C_LI) begin
            instr_o   = {{6{c[12]}}, c[12], c[6:2], 5'd0, 3'b000, c[11:7], OP_IMM};
            illegal_o = 1'b0;
          end
        end
        OPC_C2: begin
          // rs2 of zero encodes jumps, not kept
          if ((c[15:13] == F3_C_MVADD) && (c[6:2] != 5'd0)) begin
            illegal_o = 1'b0;
            if (c[12]) begin
              instr_o = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], OP_REG};
            end else begin
              instr_o = {7'b0, c[6:2], 5'd0, 3'b000, c[11:7], OP_REG};
            end
          end
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/if_id_register.sv */
////////////////////
// IF/ID register
////////////////////
`default_nettype none

module if_id_register (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        if_valid_i,
  input  logic        id_ready_i,
  input  logic [31:0] instr_i,
  input  logic [31:0] pc_i,
  input  logic        is_compressed_i,
  input  logic [15:0] raw_instr_i,
  input  logic        illegal_i,
  input  logic        err_i,
  output logic        id_valid_o,
  output logic [31:0] id_instr_o,
  output logic [31:0] id_pc_o,
  output logic        id_compressed_o,
  output logic [15:0] id_compressed_instr_o,
  output logic        id_illegal_c_o,
  output logic        id_bus_err_o
);

  logic xfer;

  assign xfer = if_valid_i && id_ready_i;

  // Valid flag, held while decode stalls
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o <= 1'b0;
    end else if (xfer) begin
      id_valid_o <= 1'b1;
    end else if (id_ready_i) begin
      id_valid_o <= 1'b0;
    end
  end

  // Payload, captured only on a transfer
  always_ff @(posedge clk) begin
    if (xfer) begin
      id_instr_o      <= instr_i;
      id_pc_o         <= pc_i;
      id_compressed_o <= is_compressed_i;
      id_illegal_c_o  <= illegal_i;
      id_bus_err_o    <= err_i;
      // Original parcel kept for illegal-instruction reporting
      if (is_compressed_i) begin
        id_compressed_instr_o <= raw_instr_i;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
////////////////////
// Fetch stage top
////////////////////
`default_nettype none

module fetch_stage (
  input  logic                                        clk,
  input  logic                                        rst_n,
  // Redirect targets
  input  logic [31:0]                                 boot_addr_i,
  input  logic [31:0]                                 jump_target_i,
  input  logic [31:0]                                 branch_target_i,
  input  logic [31:0]                                 mepc_i,
  input  logic [31:0]                                 dpc_i,
  input  logic [31:0]                                 dm_halt_addr_i,
  input  logic [31:0]                                 dm_exception_addr_i,
  input  logic [fetch_ctrl_pkg::MTVEC_ADDR_WIDTH-1:0] mtvec_addr_i,
  input  logic [fetch_ctrl_pkg::IRQ_ID_WIDTH-1:0]     irq_id_i,
  // Controller
  input  fetch_ctrl_pkg::pc_mux_e                     pc_mux_i,
  input  logic                                        pc_set_i,
  input  logic                                        halt_if_i,
  input  logic                                        kill_if_i,
  // Instruction memory
  output logic                                        instr_req_o,
  output logic [31:0]                                 instr_addr_o,
  input  logic                                        instr_rvalid_i,
  input  logic [31:0]                                 instr_rdata_i,
  input  logic                                        instr_err_i,
  // Status
  output logic                                        if_valid_o,
  output logic [31:0]                                 pc_if_o,
  output logic                                        if_busy_o,
  output logic                                        csr_mtvec_init_o,
  // Decode side
  input  logic                                        id_ready_i,
  output logic                                        id_valid_o,
  output logic [31:0]                                 id_instr_o,
  output logic [31:0]                                 id_pc_o,
  output logic                                        id_compressed_o,
  output logic [15:0]                                 id_compressed_instr_o,
  output logic                                        id_illegal_c_o,
  output logic                                        id_bus_err_o
);

  logic [31:0] branch_addr;
  logic        word_valid;
  logic        word_ready;
  logic [31:0] word;
  logic        word_err;
  logic [31:0] word_addr;
  logic [31:0] raw_instr;
  logic        is_compressed;
  logic        instr_err;
  logic [31:0] instr_exp;
  logic        illegal_c;

  pc_target_mux pc_target_mux_inst (
    .pc_mux_i            (pc_mux_i),
    .pc_set_i            (pc_set_i),
    .boot_addr_i         (boot_addr_i),
    .jump_target_i       (jump_target_i),
    .branch_target_i     (branch_target_i),
    .mepc_i              (mepc_i),
    .dpc_i               (dpc_i),
    .dm_halt_addr_i      (dm_halt_addr_i),
    .dm_exception_addr_i (dm_exception_addr_i),
    .mtvec_addr_i        (mtvec_addr_i),
    .irq_id_i            (irq_id_i),
    .branch_addr_o       (branch_addr),
    .csr_mtvec_init_o    (csr_mtvec_init_o)
  );

  prefetch_unit prefetch_unit_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (pc_set_i),
    .branch_addr_i  (branch_addr),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .word_valid_o   (word_valid),
    .word_ready_i   (word_ready),
    .word_o         (word),
    .word_err_o     (word_err),
    .word_addr_o    (word_addr),
    .busy_o         (if_busy_o)
  );

  instr_aligner instr_aligner_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc_set_i        (pc_set_i),
    .branch_addr_i   (branch_addr),
    .word_valid_i    (word_valid),
    .word_i          (word),
    .word_err_i      (word_err),
    .word_addr_i     (word_addr),
    .word_ready_o    (word_ready),
    .halt_if_i       (halt_if_i),
    .kill_if_i       (kill_if_i),
    .id_ready_i      (id_ready_i),
    .raw_instr_o     (raw_instr),
    .is_compressed_o (is_compressed),
    .instr_err_o     (instr_err),
    .pc_if_o         (pc_if_o),
    .if_valid_o      (if_valid_o)
  );

  compressed_decoder compressed_decoder_inst (
    .raw_instr_i     (raw_instr),
    .is_compressed_i (is_compressed),
    .instr_o         (instr_exp),
    .illegal_o       (illegal_c)
  );

  if_id_register if_id_register_inst (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .if_valid_i            (if_valid_o),
    .id_ready_i            (id_ready_i),
    .instr_i               (instr_exp),
    .pc_i                  (pc_if_o),
    .is_compressed_i       (is_compressed),
    .raw_instr_i           (raw_instr[15:0]),
    .illegal_i             (illegal_c),
    .err_i                 (instr_err),
    .id_valid_o            (id_valid_o),
    .id_instr_o            (id_instr_o),
    .id_pc_o               (id_pc_o),
    .id_compressed_o       (id_compressed_o),
    .id_compressed_instr_o (id_compressed_instr_o),
    .id_illegal_c_o        (id_illegal_c_o),
    .id_bus_err_o          (id_bus_err_o)
  );

endmodule

`default_nettype wire

/* tests/fetch_stage_props.sv */
////////////////////
// Fetch handshake checks
////////////////////
`default_nettype none

module fetch_stage_props (
  input wire logic        clk,
  input wire logic        rst_n,
  input wire logic        instr_req_o,
  input wire logic [31:0] instr_addr_o,
  input wire logic        instr_rvalid_i,
  input wire logic        id_ready_i,
  input wire logic        id_valid_o,
  input wire logic [31:0] id_instr_o,
  input wire logic [31:0] id_pc_o,
  input wire logic        id_compressed_o,
  input wire logic [15:0] id_compressed_instr_o,
  input wire logic        id_illegal_c_o,
  input wire logic        id_bus_err_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Requests still waiting for their response
  int open_req;
  int fail_count = 0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      open_req <= 0;
    end else begin
      open_req <= open_req + int'(instr_req_o) - int'(instr_rvalid_i);
    end
  end

  // Decode stall freezes the IF/ID contents
  stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    id_valid_o && !id_ready_i |=> id_valid_o && $stable(id_instr_o) &&
                                  $stable(id_pc_o) && $stable(id_compressed_o) &&
                                  $stable(id_compressed_instr_o) &&
                                  $stable(id_illegal_c_o) && $stable(id_bus_err_o))
    else begin
      fail_count++;
      $error("IF/ID contents changed during decode stall");
    end

  word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o |-> instr_addr_o[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("fetch address not word aligned");
    end

  // Each response needs an earlier request
  resp_matched: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> open_req > 0)
    else begin
      fail_count++;
      $error("response without a pending request");
    end

endmodule

bind fetch_stage fetch_stage_props fetch_stage_props_inst (.*);

`default_nettype wire

/* tests/tb_fetch_stage.sv */
////////////////////
// Fetch stage testbench
////////////////////
`default_nettype none

module tb_fetch_stage;
  timeunit 1ns;
  timeprecision 1ps;
  import fetch_ctrl_pkg::*;

  localparam int NUM_INSTR   = 3000;
  localparam int NUM_REDIR   = 40;
  localparam int CYCLE_LIMIT = NUM_INSTR * 12 + 8 + 4 * FETCH_DEPTH;

  logic clk = 1'b0;
  logic rst_n;
  logic [31:0] boot_addr, jump_target, branch_target, mepc, dpc, dm_halt, dm_exc;
  logic [MTVEC_ADDR_WIDTH-1:0] mtvec;
  logic [IRQ_ID_WIDTH-1:0] irq_id;
  pc_mux_e pc_mux;
  logic pc_set, halt_if, kill_if, id_ready;
  logic instr_req, instr_rvalid, instr_err;
  logic [31:0] instr_addr, instr_rdata;
  logic if_valid, if_busy, mtvec_init;
  logic [31:0] pc_if;
  logic id_valid, id_compressed, id_illegal_c, id_bus_err;
  logic [31:0] id_instr, id_pc;
  logic [15:0] id_compressed_instr;

  // Program memory, 4 KiB
  logic [31:0] mem [1024];
  logic [31:0] lfsr = 32'hed9b;
  logic [9:0]  err_lo;

  always #50 clk = ~clk;

  fetch_stage fetch_stage_inst (
    .clk(clk), .rst_n(rst_n),
    .boot_addr_i(boot_addr), .jump_target_i(jump_target),
    .branch_target_i(branch_target), .mepc_i(mepc), .dpc_i(dpc),
    .dm_halt_addr_i(dm_halt), .dm_exception_addr_i(dm_exc),
    .mtvec_addr_i(mtvec), .irq_id_i(irq_id),
    .pc_mux_i(pc_mux), .pc_set_i(pc_set), .halt_if_i(halt_if), .kill_if_i(kill_if),
    .instr_req_o(instr_req), .instr_addr_o(instr_addr), .instr_rvalid_i(instr_rvalid),
    .instr_rdata_i(instr_rdata), .instr_err_i(instr_err),
    .if_valid_o(if_valid), .pc_if_o(pc_if), .if_busy_o(if_busy),
    .csr_mtvec_init_o(mtvec_init), .id_ready_i(id_ready), .id_valid_o(id_valid),
    .id_instr_o(id_instr), .id_pc_o(id_pc), .id_compressed_o(id_compressed),
    .id_compressed_instr_o(id_compressed_instr), .id_illegal_c_o(id_illegal_c),
    .id_bus_err_o(id_bus_err)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [15:0] halfword(input logic [31:0] a);
    return a[1] ? mem[a[11:2]][31:16] : mem[a[11:2]][15:0];
  endfunction

  function automatic logic in_err_region(input logic [31:0] a);
    logic [9:0] d;
    d = a[11:2] - err_lo;
    return d < 10'd24;
  endfunction

  // Reference expansion, bit 32 flags an illegal parcel
  function automatic logic [32:0] expand_rvc(input logic [15:0] c);
    logic [11:0] uoff;
    logic [11:0] imm;
    logic [4:0]  rp1, rp2;
    uoff = {5'd0, c[5], c[12:10], c[6], 2'b00};
    imm  = {{6{c[12]}}, c[12], c[6:2]};
    rp1  = 5'd8 + c[9:7];
    rp2  = 5'd8 + c[4:2];
    if (c[1:0] == 2'b00 && c[15:13] == 3'b010)
      return {1'b0, uoff, rp1, 3'b010, rp2, 7'b0000011};
    if (c[1:0] == 2'b00 && c[15:13] == 3'b110)
      return {1'b0, uoff[11:5], rp2, rp1, 3'b010, uoff[4:0], 7'b0100011};
    if (c[1:0] == 2'b01 && c[15:13] == 3'b000)
      return {1'b0, imm, c[11:7], 3'b000, c[11:7], 7'b0010011};
    if (c[1:0] == 2'b01 && c[15:13] == 3'b010)
      return {1'b0, imm, 5'd0, 3'b000, c[11:7], 7'b0010011};
    if (c[1:0] == 2'b10 && c[15:12] == 4'b1000 && c[6:2] != 5'd0)
      return {1'b0, 7'd0, c[6:2], 5'd0, 3'b000, c[11:7], 7'b0110011};
    if (c[1:0] == 2'b10 && c[15:12] == 4'b1001 && c[6:2] != 5'd0)
      return {1'b0, 7'd0, c[6:2], c[11:7], 3'b000, c[11:7], 7'b0110011};
    return {1'b1, 16'h0000, c};
  endfunction

  // Redirect target from the mux rules
  function automatic logic [31:0] target_of(input pc_mux_e m);
    logic [31:0] base;
    base = {mtvec, 7'd0};
    case (m)
      PC_BOOT:     return boot_addr & ~32'd3;
      PC_JUMP:     return jump_target & ~32'd1;
      PC_BRANCH:   return branch_target & ~32'd1;
      PC_MRET:     return mepc & ~32'd1;
      PC_DRET:     return dpc & ~32'd1;
      PC_TRAP_EXC: return base;
      PC_TRAP_IRQ: return base + 32'(irq_id) * 4;
      PC_TRAP_DBD: return dm_halt & ~32'd3;
      PC_TRAP_DBE: return dm_exc & ~32'd3;
      default:     return base + 32'(NMI_MTVEC_INDEX) * 4;
    endcase
  endfunction

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic fill_memory();
    int h;
    logic [15:0] r;
    logic [2:0]  k;
    h = 0;
    while (h < 2048) begin
      r = lfsr_bits(16);
      k = lfsr_bits(3);
      if (k < 3) begin
        case (lfsr_bits(3) % 6)
          0: r = {3'b010, r[12:2], 2'b00};
          1: r = {3'b110, r[12:2], 2'b00};
          2: r = {3'b000, r[12:2], 2'b01};
          3: r = {3'b010, r[12:2], 2'b01};
          4: r = {4'b1000, r[11:3], 1'b1, 2'b10};
          default: r = {4'b1001, r[11:3], 1'b1, 2'b10};
        endcase
      end else if (k < 5 || h == 2047) begin
        if (r[1:0] == 2'b11) r[1:0] = 2'b10;
      end else begin
        r[1:0] = 2'b11;
      end
      if (h[0]) mem[h >> 1][31:16] = r;
      else      mem[h >> 1][15:0]  = r;
      h++;
    end
  endtask

  initial begin
    int cycle, instr_cnt, redir_cnt, next_redir, last_due, due;
    logic [31:0] addr_q[$];
    int          due_q[$];
    logic [31:0] mpc, exp_instr, exp_raw, a, fetch_exp;
    logic [32:0] ex;
    logic [15:0] hw;
    logic avail, xfer, prev_ready, set_q, exp_c, exp_ill, exp_err;
    cycle      = 0;
    instr_cnt  = 0;
    redir_cnt  = 0;
    next_redir = 0;
    last_due   = 0;
    xfer       = 1'b0;
    prev_ready = 1'b0;
    set_q      = 1'b0;
    mpc        = '0;
    fetch_exp  = '0;
    exp_instr  = '0;
    exp_raw    = '0;
    exp_c      = 1'b0;
    exp_ill    = 1'b0;
    exp_err    = 1'b0;
    rst_n         = 1'b0;
    pc_set        = 1'b0;
    halt_if       = 1'b0;
    kill_if       = 1'b0;
    id_ready      = 1'b0;
    pc_mux        = PC_BOOT;
    instr_rvalid  = 1'b0;
    instr_rdata   = '0;
    instr_err     = 1'b0;
    boot_addr     = 32'h80;
    jump_target   = '0;
    branch_target = '0;
    mepc          = '0;
    dpc           = '0;
    dm_halt       = '0;
    dm_exc        = '0;
    mtvec         = '0;
    irq_id        = '0;
    fill_memory();
    err_lo = lfsr_bits(10);
    repeat (8) @(negedge clk);
    // Outputs stay quiet while held in reset
    compare_field("instr_req_o", instr_req, 0);
    compare_field("if_valid_o", if_valid, 0);
    compare_field("id_valid_o", id_valid, 0);
    rst_n = 1'b1;
    while (instr_cnt < NUM_INSTR || redir_cnt < NUM_REDIR) begin
      @(negedge clk);
      cycle++;
      if (cycle > CYCLE_LIMIT) begin
        $display("Run timed out before all instructions reached decode");
        $display("Test FAILED");
        $fatal(1);
      end
      assert (fetch_stage_inst.fetch_stage_props_inst.fail_count == 0) else begin
        $display("A bound handshake assertion failed on the last edge");
        $display("Test FAILED");
        $fatal(1);
      end
      // Result of the previous edge
      if (xfer) begin
        compare_field("id_valid_o", id_valid, 1);
        compare_field("id_pc_o", id_pc, mpc);
        compare_field("id_instr_o", id_instr, exp_instr);
        compare_field("id_compressed_o", id_compressed, exp_c);
        compare_field("id_illegal_c_o", id_illegal_c, exp_ill);
        compare_field("id_bus_err_o", id_bus_err, exp_err);
        if (exp_c) compare_field("id_compressed_instr_o", id_compressed_instr, exp_raw);
        mpc = mpc + (exp_c ? 32'd2 : 32'd4);
        instr_cnt++;
      end else if (prev_ready) begin
        compare_field("id_valid_o", id_valid, 0);
      end
      // Busy while any request, live or flushed, still owes a response
      compare_field("if_busy_o", if_busy, addr_q.size() != 0);
      // Memory response
      instr_rvalid = 1'b0;
      if (due_q.size() > 0 && due_q[0] == cycle) begin
        a = addr_q.pop_front();
        void'(due_q.pop_front());
        instr_rvalid = 1'b1;
        instr_rdata  = mem[a[11:2]];
        instr_err    = in_err_region(a);
      end
      pc_set   = 1'b0;
      halt_if  = 1'b0;
      kill_if  = 1'b0;
      id_ready = 1'b0;
      #1;
      avail = if_valid;
      if (avail) compare_field("pc_if_o", pc_if, mpc);
      // Expected instruction at the model PC
      hw = halfword(mpc);
      exp_c = (hw[1:0] != 2'b11);
      exp_raw = {16'h0000, hw};
      ex = expand_rvc(hw);
      exp_instr = exp_c ? ex[31:0] : {halfword(mpc + 2), hw};
      exp_ill = exp_c & ex[32];
      exp_err = in_err_region(mpc) | (!exp_c & in_err_region(mpc + 2));
      xfer = 1'b0;
      if (redir_cnt == 0 || (instr_cnt >= next_redir && redir_cnt < NUM_REDIR)) begin
        // Every source in turn, boot first
        pc_mux        = pc_mux_e'(redir_cnt % 10);
        jump_target   = lfsr_bits(32);
        branch_target = lfsr_bits(32);
        mepc          = lfsr_bits(32);
        dpc           = lfsr_bits(32);
        dm_halt       = lfsr_bits(32);
        dm_exc        = lfsr_bits(32);
        mtvec         = lfsr_bits(MTVEC_ADDR_WIDTH);
        irq_id        = lfsr_bits(IRQ_ID_WIDTH);
        pc_set        = 1'b1;
        mpc           = target_of(pc_mux);
        fetch_exp     = {mpc[31:2], 2'b00};
        redir_cnt++;
        next_redir = instr_cnt + 50 + lfsr_bits(4);
      end else begin
        kill_if  = avail && (lfsr_bits(4) == 0);
        halt_if  = (lfsr_bits(3) == 0);
        id_ready = (lfsr_bits(2) != 0);
        xfer = avail && !kill_if && !halt_if && id_ready;
        // Killed instruction is consumed
        if (avail && kill_if) mpc = mpc + (exp_c ? 32'd2 : 32'd4);
      end
      prev_ready = id_ready;
      #1;
      compare_field("csr_mtvec_init_o", mtvec_init, pc_set && pc_mux == PC_BOOT);
      // Fetch from the new target starts right after a redirect
      if (set_q) begin
        compare_field("instr_req_o", instr_req, 1);
      end
      set_q = pc_set;
      if (instr_req) begin
        compare_field("instr_addr_o", instr_addr, fetch_exp);
        fetch_exp = fetch_exp + 32'd4;
        due = cycle + 1 + lfsr_bits(2);
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        addr_q.push_back(instr_addr);
        due_q.push_back(due);
      end
    end
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
rtl/fetch_ctrl_pkg.sv
rtl/rvc_pkg.sv
rtl/pc_target_mux.sv
rtl/prefetch_unit.sv
rtl/instr_aligner.sv
rtl/compressed_decoder.sv
rtl/if_id_register.sv
rtl/fetch_stage.sv
tests/fetch_stage_props.sv
tests/tb_fetch_stage.sv
